// File: alu_issue_queue.f
+incdir+include
verilog/alu_iq_pkg.sv
verilog/iq_compact_select.sv
verilog/iq_dispatch.sv
verilog/iq_entries.sv
verilog/alu_issue_queue.sv
bench/tb_alu_issue_queue.sv

// File: include/iq_tb_model.svh
`ifndef IQ_TB_MODEL_SVH
`define IQ_TB_MODEL_SVH

// --------------------------------------------------------------------------
// reference model of the collapsing queue
// --------------------------------------------------------------------------

// contents and occupancy expected after the next rising edge
iq_entry_t model_q [DEPTH];
int        model_count;

function automatic void model_reset();
	for (int i = 0; i < DEPTH; i++) begin
		model_q[i] = '0;
	end
	model_count = 0;
endfunction

// occupied slots that stay, i.e. mask bit clear below count
function automatic int model_survivors(logic [DEPTH-1:0] mask);
	int n;

	n = 0;
	for (int i = 0; i < model_count; i++) begin
		if (!mask[i]) begin
			n++;
		end
	end
	return n;
endfunction

// the offer is judged even when en is low
function automatic bit model_write_success(int num, logic [DEPTH-1:0] mask);
	return (model_survivors(mask) + num) <= DEPTH;
endfunction

// survivors in old order, then the accepted group, zero above
function automatic void model_step(iq_dispatch_t d, logic [DEPTH-1:0] mask);
	iq_entry_t next_q [DEPTH];
	int        n;
	bit        accept;

	accept = d.en && model_write_success(int'(d.num), mask);
	n = 0;
	for (int i = 0; i < DEPTH; i++) begin
		next_q[i] = '0;
	end
	for (int i = 0; i < model_count; i++) begin
		if (!mask[i]) begin
			next_q[n] = model_q[i];
			n++;
		end
	end
	if (accept) begin
		for (int k = 0; k < int'(d.num); k++) begin
			next_q[n] = d.slot[k];
			n++;
		end
	end
	model_q = next_q;
	model_count = n;
endfunction

`endif

// File: bench/tb_alu_issue_queue.sv
`timescale 1ns/100ps

module tb_alu_issue_queue;

	import alu_iq_pkg::*;

	localparam int DEPTH = 7;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	// upper bound on the directed sequence below
	localparam int DIRECTED_CYCLES = 40;
	localparam int RANDOM_CYCLES = 2000;
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 20) * CLK_PERIOD;

	logic                  clk;
	logic                  resetn;
	iq_dispatch_t          dispatch;
	logic [DEPTH-1:0]      out_en;
	iq_entry_t [DEPTH-1:0] entries;
	logic [CNT_W-1:0]      count;
	logic                  write_success;

	`include "iq_tb_model.svh"

	alu_issue_queue #(.DEPTH(DEPTH)) dut0 (
		.clk           (clk),
		.resetn        (resetn),
		.dispatch      (dispatch),
		.out_en        (out_en),
		.entries       (entries),
		.count         (count),
		.write_success (write_success)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------

	task automatic check_equal(input string name, input logic [67:0] actual,
			input logic [67:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic iq_entry_t random_entry();
		logic [95:0] bits;

		bits = {$urandom(), $urandom(), $urandom()};
		return iq_entry_t'(bits[67:0]);
	endfunction

	// slots past num get random contents too and must never land in the queue
	function automatic iq_dispatch_t make_dispatch(logic en, int num);
		iq_dispatch_t d;

		d.en = en;
		d.num = 3'(num);
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			d.slot[k] = random_entry();
		end
		return d;
	endfunction

	// zero to two bits only at occupied slots
	function automatic logic [DEPTH-1:0] random_mask(int occupied);
		logic [DEPTH-1:0] m;
		int               want;
		int               pos;

		m = '0;
		if (occupied == 0) begin
			return m;
		end
		want = $urandom_range(2, 0);
		if (want > occupied) begin
			want = occupied;
		end
		while ($countones(m) < want) begin
			pos = $urandom_range(occupied - 1, 0);
			m[pos] = 1'b1;
		end
		return m;
	endfunction

	task automatic check_state();
		check_equal("count", 68'(count), 68'(model_count));
		for (int i = 0; i < DEPTH; i++) begin
			check_equal($sformatf("entries[%0d]", i), entries[i], model_q[i]);
		end
	endtask

	// check the last edge, drive, then check write_success before the next edge
	task automatic step(input iq_dispatch_t d, input logic [DEPTH-1:0] mask);
		bit exp_ws;

		@(posedge clk);
		#1;
		check_state();
		#1;
		dispatch = d;
		out_en = mask;
		exp_ws = model_write_success(int'(d.num), mask);
		@(negedge clk);
		check_equal("write_success", 68'(write_success), 68'(exp_ws));
		model_step(d, mask);
	endtask

	// --------------------------------------------------------------------------
	// stimulus
	// --------------------------------------------------------------------------

	initial begin
		void'($urandom(32'h5000_f149));
		resetn = 1'b0;
		dispatch = '0;
		out_en = '0;
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		resetn = 1'b1;

		// empty queue takes a full group
		step(make_dispatch(1'b1, 4), 7'b0000000);

		// fill by writes only, with offers that do not fit
		step(make_dispatch(1'b1, 3), 7'b0000000);
		step(make_dispatch(1'b1, 3), 7'b0000000);
		step(make_dispatch(1'b1, 2), 7'b0000000);
		step(make_dispatch(1'b1, 1), 7'b0000000);
		step(make_dispatch(1'b1, 1), 7'b0000000);
		step(make_dispatch(1'b1, 0), 7'b0000000);

		// removal only
		step(make_dispatch(1'b0, 0), 7'b0000100);
		step(make_dispatch(1'b0, 0), 7'b0100001);
		step(make_dispatch(1'b0, 0), 7'b0001000);
		step(make_dispatch(1'b0, 0), 7'b0000011);

		// refill, then remove and append in the same cycle from a full queue
		step(make_dispatch(1'b1, 4), 7'b0000000);
		step(make_dispatch(1'b1, 2), 7'b0000000);
		step(make_dispatch(1'b1, 2), 7'b1000010);
		step(make_dispatch(1'b1, 1), 7'b0010000);

		// rejected group while removing
		step(make_dispatch(1'b1, 4), 7'b0000101);
		step(make_dispatch(1'b1, 3), 7'b0000001);
		step(make_dispatch(1'b0, 4), 7'b0000011);

		repeat (RANDOM_CYCLES) begin
			step(make_dispatch(($urandom_range(3, 0) != 0), $urandom_range(4, 0)),
				random_mask(model_count));
		end

		@(posedge clk);
		#1;
		check_state();
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the test did not complete within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the ALU issue queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_alu_issue_queue \
	-f alu_issue_queue.f

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/Vtb_alu_issue_queue

// File: verilog/alu_iq_pkg.sv
package alu_iq_pkg;

	// --------------------------------------------------------------------------
	// queue sizing
	// --------------------------------------------------------------------------

	// default number of queue entries
	localparam int IQ_DEPTH = 7;

	// up to four micro-ops arrive from rename per cycle
	localparam int DISPATCH_WIDTH = 4;

	// the ALU pipes can retire two entries per cycle
	localparam int ISSUE_WIDTH = 2;

	// --------------------------------------------------------------------------
	// entry and dispatch formats
	// --------------------------------------------------------------------------

	// one ALU micro-op as held in a queue slot, 68 bits
	typedef struct packed {
		logic [4:0]  src_l;
		logic        val_l;
		logic        rdy_l;
		logic [4:0]  src_r;
		logic        val_r;
		logic        rdy_r;
		logic [4:0]  dest;
		// right operand comes from imm when set
		logic        imm_valid;
		logic [31:0] imm;
		logic [14:0] alu_ctrl;
		logic        issued;
	} iq_entry_t;

	// the group offered by dispatch in one cycle
	typedef struct packed {
		logic                           en;
		// number of valid slots, 0 to DISPATCH_WIDTH
		logic [2:0]                     num;
		// slot[0] is the oldest micro-op of the group
		iq_entry_t [DISPATCH_WIDTH-1:0] slot;
	} iq_dispatch_t;

	// how far up a slot reaches for its next content, 0 to 2
	typedef logic [1:0] iq_shift_t;

endpackage

// File: verilog/alu_issue_queue.sv
`timescale 1ns/100ps

module alu_issue_queue #(
	parameter int DEPTH = alu_iq_pkg::IQ_DEPTH,
	localparam int CNT_W = $clog2(DEPTH + 1)
) (
	input  logic                             clk,
	input  logic                             resetn,
	input  alu_iq_pkg::iq_dispatch_t          dispatch,
	// bit i retires slot i
	input  logic [DEPTH-1:0]                 out_en,
	output alu_iq_pkg::iq_entry_t [DEPTH-1:0] entries,
	output logic [CNT_W-1:0]                 count,
	output logic                             write_success
);

	import alu_iq_pkg::*;

	iq_shift_t [DEPTH-1:0] shift;
	logic [1:0]            remove_num;
	logic [CNT_W-1:0]      w_ptr;
	logic [2:0]            write_num_acc;

	// --------------------------------------------------------------------------
	// removal mask to per-slot shifts
	// --------------------------------------------------------------------------

	iq_compact_select #(.DEPTH(DEPTH)) u_select (
		.out_en     (out_en),
		.shift      (shift),
		.remove_num (remove_num)
	);

	iq_dispatch #(.DEPTH(DEPTH)) u_dispatch (
		.clk           (clk),
		.resetn        (resetn),
		.dispatch      (dispatch),
		.remove_num    (remove_num),
		.write_success (write_success),
		.w_ptr         (w_ptr),
		.write_num_acc (write_num_acc),
		.count         (count)
	);

	iq_entries #(.DEPTH(DEPTH)) u_entries (
		.clk           (clk),
		.resetn        (resetn),
		.shift         (shift),
		.w_ptr         (w_ptr),
		.write_num_acc (write_num_acc),
		.slot          (dispatch.slot),
		.entries       (entries)
	);

	// issue may only pick occupied slots
	a_mask_below_count: assert property (
		@(posedge clk) disable iff (!resetn)
		(out_en >> count) == '0
	);

endmodule

// File: verilog/iq_compact_select.sv
`timescale 1ns/100ps

module iq_compact_select #(
	parameter int DEPTH = alu_iq_pkg::IQ_DEPTH
) (
	input  logic [DEPTH-1:0]                 out_en,
	output alu_iq_pkg::iq_shift_t [DEPTH-1:0] shift,
	output logic [1:0]                       remove_num
);

	import alu_iq_pkg::*;

	// mask with one clear bit on top so slot j can look at slot j+1
	logic [DEPTH:0] en_ext;

	assign en_ext = {1'b0, out_en};

	// --------------------------------------------------------------------------
	// per-slot shift
	// --------------------------------------------------------------------------

	// slot j receives the j-th survivor. with at most two removals the
	// running count of retired entries up to j decides the distance:
	//   none retired so far     -> keep
	//   one retired so far      -> one up, or two up if slot j+1 goes too
	//   two retired so far      -> two up
	always_comb begin
		logic [1:0] retired;

		retired = 2'd0;
		for (int j = 0; j < DEPTH; j++) begin
			retired = retired + {1'b0, out_en[j]};
			case (retired)
				2'd0: begin
					shift[j] = 2'd0;
				end
				2'd1: begin
					shift[j] = en_ext[j + 1] ? 2'd2 : 2'd1;
				end
				default: begin
					shift[j] = 2'd2;
				end
			endcase
		end
		// the chain total is the number leaving the queue this cycle
		remove_num = retired;
	end

	// more than two would wrap the 2-bit running count
	always_comb begin
		a_issue_width: assert ($countones(out_en) <= ISSUE_WIDTH);
	end

endmodule

// File: verilog/iq_dispatch.sv
`timescale 1ns/100ps

module iq_dispatch #(
	parameter int DEPTH = alu_iq_pkg::IQ_DEPTH,
	localparam int CNT_W = $clog2(DEPTH + 1)
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  alu_iq_pkg::iq_dispatch_t dispatch,
	input  logic [1:0]              remove_num,
	output logic                    write_success,
	output logic [CNT_W-1:0]        w_ptr,
	output logic [2:0]              write_num_acc,
	output logic [CNT_W-1:0]        count
);

	import alu_iq_pkg::*;

	logic [CNT_W-1:0] remove_ext;

	// --------------------------------------------------------------------------
	// survivors and acceptance
	// --------------------------------------------------------------------------

	assign remove_ext = CNT_W'(remove_num);

	// survivors after this cycle's retirement, where appended micro-ops start
	always_comb begin
		if (remove_ext > count) begin
			w_ptr = '0;
		end else begin
			w_ptr = count - remove_ext;
		end
	end

	// all or nothing, a group that does not fit is offered again next cycle
	assign write_success = (int'(w_ptr) + int'(dispatch.num)) <= DEPTH;

	// num of zero falls through as an empty write
	assign write_num_acc = (dispatch.en && write_success) ? dispatch.num : 3'd0;

	// --------------------------------------------------------------------------
	// occupancy
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= '0;
		end else begin
			count <= w_ptr + CNT_W'(write_num_acc);
		end
	end

	a_num_legal: assert property (
		@(posedge clk) disable iff (!resetn)
		dispatch.en |-> int'(dispatch.num) <= DISPATCH_WIDTH
	);

	// the select logic only sees the mask, so the bound against count is checked here
	a_remove_le_count: assert property (
		@(posedge clk) disable iff (!resetn)
		remove_ext <= count
	);

	a_count_bound: assert property (
		@(posedge clk) disable iff (!resetn)
		int'(count) <= DEPTH
	);

endmodule

// File: verilog/iq_entries.sv
`timescale 1ns/100ps

module iq_entries #(
	parameter int DEPTH = alu_iq_pkg::IQ_DEPTH,
	localparam int CNT_W = $clog2(DEPTH + 1)
) (
	input  logic                                                clk,
	input  logic                                                resetn,
	input  alu_iq_pkg::iq_shift_t [DEPTH-1:0]                    shift,
	input  logic [CNT_W-1:0]                                    w_ptr,
	input  logic [2:0]                                          write_num_acc,
	input  alu_iq_pkg::iq_entry_t [alu_iq_pkg::DISPATCH_WIDTH-1:0] slot,
	output alu_iq_pkg::iq_entry_t [DEPTH-1:0]                    entries
);

	import alu_iq_pkg::*;

	// two zero entries above the top so a shift past the end reads empty
	iq_entry_t [DEPTH+1:0] src;
	iq_entry_t [DEPTH-1:0] shifted;
	iq_entry_t [DEPTH-1:0] entries_next;

	// --------------------------------------------------------------------------
	// compaction
	// --------------------------------------------------------------------------

	assign src = {{2{iq_entry_t'('0)}}, entries};

	always_comb begin
		for (int j = 0; j < DEPTH; j++) begin
			case (shift[j])
				2'd0: begin
					shifted[j] = src[j];
				end
				2'd1: begin
					shifted[j] = src[j + 1];
				end
				default: begin
					shifted[j] = src[j + 2];
				end
			endcase
		end
	end

	// --------------------------------------------------------------------------
	// append and clear
	// --------------------------------------------------------------------------

	// below w_ptr the compacted survivors, then the accepted group in
	// dispatch order, zero above that
	always_comb begin
		for (int j = 0; j < DEPTH; j++) begin
			entries_next[j] = '0;
			if (j < int'(w_ptr)) begin
				entries_next[j] = shifted[j];
			end else begin
				for (int k = 0; k < DISPATCH_WIDTH; k++) begin
					if (k < int'(write_num_acc) && j == int'(w_ptr) + k) begin
						entries_next[j] = slot[k];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			entries <= '0;
		end else begin
			entries <= entries_next;
		end
	end

endmodule
